// ==== build.f ====
+incdir+source
source/cnn_pkg.sv
source/cnn_regs.sv
source/cnn_sequencer.sv
source/conv_layer.sv
source/pool_layer.sv
source/fc_layer.sv
source/cnn_top.sv
tb/tb_cnn_top.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_cnn_top

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

$(SIM): build.f source/*.sv source/*.svh tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_cnn_top

clean:
	rm -rf obj_dir

// ==== tb/tb_cnn_top.sv ====
`timescale 1ns/10ps
`include "cnn_defines.svh"

module tb_cnn_top import cnn_pkg::*; ();

    localparam int run_cycles     = 63;
    localparam int timeout_cycles = 20 * 300;
    localparam int img_n          = `CNN_IMG_DIM * `CNN_IMG_DIM;
    localparam int k_n            = `CNN_K_DIM * `CNN_K_DIM;

    logic              clk = 1'b0;
    logic              rst;
    axil_req_t         req;
    axil_rsp_t         rsp;
    int                cycle_count = 0;
    int unsigned       lcg_state = 7326;
    logic signed [7:0] img_m [img_n];
    logic signed [7:0] krn_m [k_n];
    logic signed [7:0] fcw_m [k_n];
    logic [31:0]       last_model;

    cnn_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .axil_req (req),
        .axil_rsp (rsp)
    );

    always #2 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, the tests did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: time %0t, %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // software conv, pool and fc with every sum wrapping at 32 bits
    function automatic logic [31:0] model_result();
        int conv_m [36];
        int pool_m [9];
        int s;
        int m;
        int base;
        int acc;
        for (int r = 0; r < `CNN_CONV_DIM; r++) begin
            for (int c = 0; c < `CNN_CONV_DIM; c++) begin
                s = 0;
                for (int ki = 0; ki < `CNN_K_DIM; ki++) begin
                    for (int kj = 0; kj < `CNN_K_DIM; kj++) begin
                        s = s + int'(img_m[(r + ki) * `CNN_IMG_DIM + c + kj])
                              * int'(krn_m[ki * `CNN_K_DIM + kj]);
                    end
                end
                conv_m[r * `CNN_CONV_DIM + c] = s;
            end
        end
        for (int pr = 0; pr < `CNN_POOL_DIM; pr++) begin
            for (int pc = 0; pc < `CNN_POOL_DIM; pc++) begin
                base = 2 * pr * `CNN_CONV_DIM + 2 * pc;
                m = conv_m[base];
                if (conv_m[base + 1] > m) m = conv_m[base + 1];
                if (conv_m[base + `CNN_CONV_DIM] > m) m = conv_m[base + `CNN_CONV_DIM];
                if (conv_m[base + `CNN_CONV_DIM + 1] > m) m = conv_m[base + `CNN_CONV_DIM + 1];
                pool_m[pr * `CNN_POOL_DIM + pc] = m;
            end
        end
        acc = 0;
        for (int i = 0; i < k_n; i++) begin
            acc = acc + pool_m[i] * int'(fcw_m[i]);
        end
        return acc;
    endfunction

    // stall holds bready low for that many cycles once bvalid is up
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data, input int stall);
        @(negedge clk);
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hf;
        req.bready  = (stall == 0);
        @(negedge clk);
        while (!rsp.awready) @(negedge clk);
        check("wready", {31'b0, rsp.wready}, 32'h1);
        @(negedge clk);
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        while (!rsp.bvalid) @(negedge clk);
        repeat (stall) begin
            @(negedge clk);
            check("bvalid", {31'b0, rsp.bvalid}, 32'h1);
        end
        req.bready = 1'b1;
        check("bresp", {30'b0, rsp.bresp}, 32'h0);
        @(negedge clk);
        check("bvalid", {31'b0, rsp.bvalid}, 32'h0);
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data, input int stall);
        @(negedge clk);
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.rready  = (stall == 0);
        @(negedge clk);
        while (!rsp.arready) @(negedge clk);
        @(negedge clk);
        req.arvalid = 1'b0;
        while (!rsp.rvalid) @(negedge clk);
        repeat (stall) begin
            @(negedge clk);
            check("rvalid", {31'b0, rsp.rvalid}, 32'h1);
        end
        req.rready = 1'b1;
        data = rsp.rdata;
        check("rresp", {30'b0, rsp.rresp}, 32'h0);
        @(negedge clk);
        check("rvalid", {31'b0, rsp.rvalid}, 32'h0);
        req.rready = 1'b0;
    endtask

    task automatic load_all();
        for (int i = 0; i < img_n; i++) begin
            axil_write(`CNN_REG_IMAGE + 12'(4 * i), {24'h0, img_m[i]}, 0);
        end
        for (int i = 0; i < k_n; i++) begin
            axil_write(`CNN_REG_KERNEL + 12'(4 * i), {24'h0, krn_m[i]}, 0);
            axil_write(`CNN_REG_FC_W + 12'(4 * i), {24'h0, fcw_m[i]}, 0);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < img_n; i++) img_m[i] = next_rand();
        for (int i = 0; i < k_n; i++) krn_m[i] = next_rand();
        for (int i = 0; i < k_n; i++) fcw_m[i] = next_rand();
    endtask

    // start, poll until done and idle, then fetch the result
    task automatic run_and_read(output logic [31:0] res);
        logic [31:0] status;
        axil_write(`CNN_REG_CTRL, 32'h1, 0);
        do begin
            axil_read(`CNN_REG_STATUS, status, 0);
        end while (status != 32'h1);
        axil_read(`CNN_REG_RESULT, res, 0);
    endtask

    task automatic reset_state_test();
        logic [31:0] data;
        axil_read(`CNN_REG_STATUS, data, 0);
        check("status", data, 32'h0);
        axil_read(`CNN_REG_RESULT, data, 0);
        check("result", data, 32'h0);
    endtask

    task automatic center_tap_case();
        logic [31:0] res;
        for (int i = 0; i < img_n; i++) img_m[i] = 8'(i);
        for (int i = 0; i < k_n; i++) krn_m[i] = 8'sd0;
        for (int i = 0; i < k_n; i++) fcw_m[i] = 8'sd1;
        krn_m[4] = 8'sd1;
        load_all();
        last_model = model_result();
        run_and_read(res);
        check("result", res, last_model);
    endtask

    task automatic random_cases();
        logic [31:0] res;
        logic [31:0] status;
        repeat (5) begin
            fill_random();
            load_all();
            last_model = model_result();
            run_and_read(res);
            check("result", res, last_model);
            axil_read(`CNN_REG_STATUS, status, 0);
            check("status", status, 32'h1);
        end
    endtask

    // read-only and unmapped offsets take writes with no effect
    task automatic result_write_ignored();
        logic [31:0] data;
        axil_write(`CNN_REG_RESULT, 32'hdead_beef, 0);
        axil_write(12'h0f0, 32'h1234_5678, 0);
        axil_read(`CNN_REG_RESULT, data, 0);
        check("result", data, last_model);
        axil_read(12'h0f0, data, 0);
        check("unmapped rdata", data, 32'h0);
    endtask

    task automatic start_during_run();
        logic [31:0] res;
        logic [31:0] status;
        int          t0;
        int          elapsed;
        fill_random();
        load_all();
        last_model = model_result();
        t0 = cycle_count;
        axil_write(`CNN_REG_CTRL, 32'h1, 0);
        repeat (20) @(negedge clk);
        axil_read(`CNN_REG_STATUS, status, 0);
        check("status", status, 32'h2);
        axil_write(`CNN_REG_CTRL, 32'h1, 0);
        do begin
            axil_read(`CNN_REG_STATUS, status, 0);
        end while (status != 32'h1);
        elapsed = cycle_count - t0;
        // a restart at cycle 20 could not finish this early
        if (elapsed > run_cycles + 16) begin
            $display("a start written during the run restarted it, done after %0d cycles",
                     elapsed);
            $display("Test failed");
            $fatal(1);
        end
        axil_read(`CNN_REG_RESULT, res, 0);
        check("result", res, last_model);
        for (int i = 0; i < k_n; i++) begin
            fcw_m[i] = next_rand();
            axil_write(`CNN_REG_FC_W + 12'(4 * i), {24'h0, fcw_m[i]}, 0);
        end
        last_model = model_result();
        run_and_read(res);
        check("result", res, last_model);
    endtask

    task automatic response_stall();
        logic [31:0] data;
        axil_read(`CNN_REG_RESULT, data, 6);
        check("result", data, last_model);
        axil_read(`CNN_REG_STATUS, data, 4);
        check("status", data, 32'h1);
        fcw_m[0] = next_rand();
        axil_write(`CNN_REG_FC_W, {24'h0, fcw_m[0]}, 5);
        last_model = model_result();
        run_and_read(data);
        check("result", data, last_model);
    endtask

    initial begin
        req = '0;
        rst = 1'b1;
        last_model = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_state_test();
        center_tap_case();
        random_cases();
        result_write_ignored();
        start_during_run();
        response_stall();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== source/cnn_top.sv ====
`timescale 1ns/10ps

module cnn_top import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);

    image_t    image;
    kernel_t   kernel;
    kernel_t   fc_weights;
    logic      go;
    logic      busy;
    logic      done;
    acc_t      result;
    logic      conv_start;
    logic      pool_start;
    logic      fc_start;
    logic      conv_done;
    logic      pool_done;
    logic      fc_done;
    conv_map_t conv_map;
    pool_map_t pool_map;

    cnn_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .image      (image),
        .kernel     (kernel),
        .fc_weights (fc_weights),
        .go         (go),
        .busy       (busy),
        .done       (done),
        .result     (result)
    );

    cnn_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .go         (go),
        .conv_start (conv_start),
        .pool_start (pool_start),
        .fc_start   (fc_start),
        .conv_done  (conv_done),
        .pool_done  (pool_done),
        .fc_done    (fc_done),
        .busy       (busy),
        .done       (done)
    );

    // layer 1, 8x8 image to 6x6 map
    conv_layer u_conv (
        .clk      (clk),
        .rst      (rst),
        .start    (conv_start),
        .image    (image),
        .kernel   (kernel),
        .done     (conv_done),
        .conv_map (conv_map)
    );

    // layer 2, 6x6 to 3x3
    pool_layer u_pool (
        .clk      (clk),
        .rst      (rst),
        .start    (pool_start),
        .conv_map (conv_map),
        .done     (pool_done),
        .pool_map (pool_map)
    );

    // layer 3, dot product with the fc weights
    fc_layer u_fc (
        .clk      (clk),
        .rst      (rst),
        .start    (fc_start),
        .pool_map (pool_map),
        .weights  (fc_weights),
        .done     (fc_done),
        .result   (result)
    );

endmodule

// ==== source/fc_layer.sv ====
`timescale 1ns/10ps
`include "cnn_defines.svh"

module fc_layer import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  pool_map_t pool_map,
    input  kernel_t   weights,
    output logic      done,
    output acc_t      result
);

    localparam int n_terms = `CNN_POOL_DIM * `CNN_POOL_DIM;

    logic                       running;
    logic [$clog2(n_terms)-1:0] idx;
    acc_t                       acc;
    acc_t                       term;

    // 32-bit product, upper bits dropped on purpose
    assign term   = acc_t'(signed'(pool_map[idx])) * acc_t'(signed'(weights[idx]));
    assign result = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            idx     <= '0;
            acc     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                idx     <= '0;
                acc     <= '0;
            end else if (running) begin
                acc <= acc + term;
                if (idx == n_terms - 1) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    a_done_after_start: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(start, n_terms + 1));

endmodule

// ==== source/pool_layer.sv ====
`timescale 1ns/10ps
`include "cnn_defines.svh"

module pool_layer import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  conv_map_t conv_map,
    output logic      done,
    output pool_map_t pool_map
);

    localparam int pos_w = $clog2(`CNN_POOL_DIM);
    localparam int last  = `CNN_POOL_DIM - 1;

    logic             running;
    logic [pos_w-1:0] pr;
    logic [pos_w-1:0] pc;
    int               base;
    acc_t             top_max;
    acc_t             bot_max;
    acc_t             win_max;

    // top left of the 2x2 window, stride 2
    always_comb begin
        base    = 2 * pr * `CNN_CONV_DIM + 2 * pc;
        top_max = (conv_map[base] > conv_map[base + 1]) ? conv_map[base] : conv_map[base + 1];
        bot_max = (conv_map[base + `CNN_CONV_DIM] > conv_map[base + `CNN_CONV_DIM + 1])
                ? conv_map[base + `CNN_CONV_DIM] : conv_map[base + `CNN_CONV_DIM + 1];
        win_max = (top_max > bot_max) ? top_max : bot_max;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            pr      <= '0;
            pc      <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                pr      <= '0;
                pc      <= '0;
            end else if (running) begin
                if (pc == last) begin
                    pc <= '0;
                    if (pr == last) begin
                        running <= 1'b0;
                        done    <= 1'b1;
                    end else begin
                        pr <= pr + 1'b1;
                    end
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) pool_map[pr * `CNN_POOL_DIM + pc] <= win_max;
    end

endmodule

// ==== source/conv_layer.sv ====
`timescale 1ns/10ps
`include "cnn_defines.svh"

module conv_layer import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  image_t    image,
    input  kernel_t   kernel,
    output logic      done,
    output conv_map_t conv_map
);

    localparam int pos_w = $clog2(`CNN_CONV_DIM);
    localparam int last  = `CNN_CONV_DIM - 1;

    logic             running;
    logic [pos_w-1:0] row;
    logic [pos_w-1:0] col;
    acc_t             sum;

    // nine sign-extended products for the window at row, col
    always_comb begin
        sum = '0;
        for (int ki = 0; ki < `CNN_K_DIM; ki++) begin
            for (int kj = 0; kj < `CNN_K_DIM; kj++) begin
                sum = sum
                    + acc_t'(signed'(image[(row + ki) * `CNN_IMG_DIM + col + kj]))
                    * acc_t'(signed'(kernel[ki * `CNN_K_DIM + kj]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            row     <= '0;
            col     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                row     <= '0;
                col     <= '0;
            end else if (running) begin
                if (col == last) begin
                    col <= '0;
                    if (row == last) begin
                        running <= 1'b0;
                        done    <= 1'b1;
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running) conv_map[row * `CNN_CONV_DIM + col] <= sum;
    end

endmodule

// ==== source/cnn_sequencer.sv ====
`timescale 1ns/10ps

module cnn_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic go,
    output logic conv_start,
    output logic pool_start,
    output logic fc_start,
    input  logic conv_done,
    input  logic pool_done,
    input  logic fc_done,
    output logic busy,
    output logic done
);

    typedef enum logic [2:0] {
        IDLE,
        CONV_WAIT,
        POOL_START,
        POOL_WAIT,
        FC_START,
        FC_WAIT,
        DONE
    } state_t;

    state_t state;

    assign busy = state != IDLE && state != DONE;
    assign done = state == DONE;

    // go to done status is 63 cycles: 37 + 10 + 10 in the layers plus launch gaps
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            fc_start   <= 1'b0;
        end else begin
            conv_start <= 1'b0;
            pool_start <= 1'b0;
            fc_start   <= 1'b0;
            case (state)
                IDLE, DONE: begin
                    if (go) begin
                        conv_start <= 1'b1;
                        state      <= CONV_WAIT;
                    end
                end
                CONV_WAIT: begin
                    if (conv_done) state <= POOL_START;
                end
                POOL_START: begin
                    pool_start <= 1'b1;
                    state      <= POOL_WAIT;
                end
                POOL_WAIT: begin
                    if (pool_done) state <= FC_START;
                end
                FC_START: begin
                    fc_start <= 1'b1;
                    state    <= FC_WAIT;
                end
                FC_WAIT: begin
                    if (fc_done) state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_one_start: assert property (@(posedge clk) disable iff (rst)
        $onehot0({conv_start, pool_start, fc_start}));

endmodule

// ==== source/cnn_regs.sv ====
`timescale 1ns/10ps
`include "cnn_defines.svh"

module cnn_regs import cnn_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output image_t    image,
    output kernel_t   kernel,
    output kernel_t   fc_weights,
    output logic      go,
    input  logic      busy,
    input  logic      done,
    input  acc_t      result
);

    localparam int img_n     = `CNN_IMG_DIM * `CNN_IMG_DIM;
    localparam int k_n       = `CNN_K_DIM * `CNN_K_DIM;
    localparam int img_idx_w = $clog2(img_n);
    localparam int k_idx_w   = $clog2(k_n);

    logic                   aw_ready;
    logic                   ar_ready;
    logic                   b_valid;
    logic                   r_valid;
    logic [`CNN_DATA_W-1:0] r_data;
    logic                   idle;
    logic                   wr_take;
    logic                   rd_take;
    logic [`CNN_ADDR_W-1:0] img_off;
    logic [`CNN_ADDR_W-1:0] krn_off;
    logic [`CNN_ADDR_W-1:0] fcw_off;

    // one transaction in flight, writes win a tie
    assign idle    = !aw_ready && !ar_ready && !b_valid && !r_valid;
    assign wr_take = idle && axil_req.awvalid && axil_req.wvalid;
    assign rd_take = idle && axil_req.arvalid && !wr_take;

    // offsets into each array region, out of range wraps high
    assign img_off = axil_req.awaddr - `CNN_REG_IMAGE;
    assign krn_off = axil_req.awaddr - `CNN_REG_KERNEL;
    assign fcw_off = axil_req.awaddr - `CNN_REG_FC_W;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_ready <= 1'b0;
            ar_ready <= 1'b0;
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
            go       <= 1'b0;
        end else begin
            aw_ready <= wr_take;
            ar_ready <= rd_take;
            // start is dropped while a run is in progress
            go <= aw_ready && axil_req.awaddr == `CNN_REG_CTRL && axil_req.wstrb[0]
                  && axil_req.wdata[0] && !busy;
            if (aw_ready) begin
                b_valid <= 1'b1;
            end else if (axil_req.bready) begin
                b_valid <= 1'b0;
            end
            if (ar_ready) begin
                r_valid <= 1'b1;
            end else if (axil_req.rready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // pixel and weight storage, one value per word in the low byte
    always_ff @(posedge clk) begin
        if (aw_ready && axil_req.wstrb[0]) begin
            if (img_off[`CNN_ADDR_W-1:2] < img_n) begin
                image[img_off[2 +: img_idx_w]] <= axil_req.wdata[`CNN_PIX_W-1:0];
            end
            if (krn_off[`CNN_ADDR_W-1:2] < k_n) begin
                kernel[krn_off[2 +: k_idx_w]] <= axil_req.wdata[`CNN_PIX_W-1:0];
            end
            if (fcw_off[`CNN_ADDR_W-1:2] < k_n) begin
                fc_weights[fcw_off[2 +: k_idx_w]] <= axil_req.wdata[`CNN_PIX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_ready) begin
            case (axil_req.araddr)
                `CNN_REG_STATUS: r_data <= {{(`CNN_DATA_W-2){1'b0}}, busy, done};
                `CNN_REG_RESULT: r_data <= result;
                default:         r_data <= '0;
            endcase
        end
    end

    // every response is OKAY
    always_comb begin
        axil_rsp.awready = aw_ready;
        axil_rsp.wready  = aw_ready;
        axil_rsp.bvalid  = b_valid;
        axil_rsp.bresp   = 2'b00;
        axil_rsp.arready = ar_ready;
        axil_rsp.rvalid  = r_valid;
        axil_rsp.rdata   = r_data;
        axil_rsp.rresp   = 2'b00;
    end

    a_one_response: assert property (@(posedge clk) disable iff (rst)
        !(b_valid && r_valid));

endmodule

// ==== source/cnn_pkg.sv ====
package cnn_pkg;

`include "cnn_defines.svh"

    typedef logic signed [`CNN_PIX_W-1:0] pixel_t;
    typedef logic signed [`CNN_ACC_W-1:0] acc_t;

    // row-major maps, element 0 is the top left
    typedef pixel_t [`CNN_IMG_DIM*`CNN_IMG_DIM-1:0]   image_t;
    typedef pixel_t [`CNN_K_DIM*`CNN_K_DIM-1:0]       kernel_t;
    typedef acc_t   [`CNN_CONV_DIM*`CNN_CONV_DIM-1:0] conv_map_t;
    typedef acc_t   [`CNN_POOL_DIM*`CNN_POOL_DIM-1:0] pool_map_t;

    // host to slave
    typedef struct packed {
        logic                      awvalid;
        logic [`CNN_ADDR_W-1:0]    awaddr;
        logic                      wvalid;
        logic [`CNN_DATA_W-1:0]    wdata;
        logic [`CNN_DATA_W/8-1:0]  wstrb;
        logic                      bready;
        logic                      arvalid;
        logic [`CNN_ADDR_W-1:0]    araddr;
        logic                      rready;
    } axil_req_t;

    // slave to host
    typedef struct packed {
        logic                      awready;
        logic                      wready;
        logic                      bvalid;
        logic [1:0]                bresp;
        logic                      arready;
        logic                      rvalid;
        logic [`CNN_DATA_W-1:0]    rdata;
        logic [1:0]                rresp;
    } axil_rsp_t;

endpackage

// ==== source/cnn_defines.svh ====
`ifndef CNN_DEFINES_SVH
`define CNN_DEFINES_SVH

// image and layer geometry
`define CNN_IMG_DIM   8
`define CNN_K_DIM     3
`define CNN_CONV_DIM  6
`define CNN_POOL_DIM  3

// data widths
`define CNN_PIX_W     8
`define CNN_ACC_W     32
`define CNN_DATA_W    32
`define CNN_ADDR_W    12

// register byte offsets
`define CNN_REG_CTRL    12'h000
`define CNN_REG_STATUS  12'h004
`define CNN_REG_RESULT  12'h008
`define CNN_REG_KERNEL  12'h040
`define CNN_REG_FC_W    12'h080
`define CNN_REG_IMAGE   12'h100

`endif
